// File: source/tile_io_pkg.sv
package tile_io_pkg;

  localparam int paddr_w_p = 40;
  localparam int data_w_p  = 64;
  localparam int num_src_p = 2;
  localparam int num_dev_p = 3;

  typedef logic [paddr_w_p-1:0]         paddr_t;
  typedef logic [data_w_p-1:0]          data_t;
  typedef logic [$clog2(num_src_p)-1:0] src_id_t;
  typedef logic [$clog2(num_dev_p)-1:0] dev_sel_t;

  // one address, seen raw or as the local device map split
  typedef union packed
  {
    paddr_t raw;
    struct packed
    {
      logic [15:0] upper;
      logic [3:0]  dev;
      logic [19:0] offset;
    } local_addr;
  } tile_addr_u;

  // device field values, address bits 23:20
  localparam logic [3:0] cfg_dev_id_p   = 4'd2;
  localparam logic [3:0] clint_dev_id_p = 4'd3;

  // crossbar port order
  localparam dev_sel_t dev_cfg_p      = 2'd0;
  localparam dev_sel_t dev_clint_p    = 2'd1;
  localparam dev_sel_t dev_loopback_p = 2'd2;

  localparam logic [19:0] cfg_freeze_offset_p     = 20'h00004;
  localparam logic [19:0] cfg_boot_npc_offset_p   = 20'h00008;
  localparam logic [19:0] cfg_core_id_offset_p    = 20'h0000c;
  localparam logic [19:0] clint_mipi_offset_p     = 20'h00000;
  localparam logic [19:0] clint_mtimecmp_offset_p = 20'h04000;
  localparam logic [19:0] clint_mtime_offset_p    = 20'h0bff8;

  localparam data_t boot_npc_reset_p = 64'h0000_0000_8000_0000;
  localparam data_t core_id_p        = 64'd5;
  // compare value out of reach, so no timer irq after reset
  localparam data_t mtimecmp_reset_p = '1;

endpackage

// File: source/tile_fwd_router.sv
`timescale 1ns/1ps

module tile_fwd_router
  (input                                                           clk_i
   , input                                                         reset_i

   , input        [tile_io_pkg::num_src_p-1:0]                     src_v_i
   , input        tile_io_pkg::tile_addr_u [tile_io_pkg::num_src_p-1:0] src_addr_i
   , input        [tile_io_pkg::num_src_p-1:0]                     src_we_i
   , input        tile_io_pkg::data_t [tile_io_pkg::num_src_p-1:0] src_wdata_i
   , output logic [tile_io_pkg::num_src_p-1:0]                     src_ready_o

   , output logic [tile_io_pkg::num_dev_p-1:0]                     dev_v_o
   , output tile_io_pkg::tile_addr_u [tile_io_pkg::num_dev_p-1:0]  dev_addr_o
   , output logic [tile_io_pkg::num_dev_p-1:0]                     dev_we_o
   , output tile_io_pkg::data_t [tile_io_pkg::num_dev_p-1:0]       dev_wdata_o
   , output tile_io_pkg::src_id_t [tile_io_pkg::num_dev_p-1:0]     dev_src_o
   , input        [tile_io_pkg::num_dev_p-1:0]                     dev_ready_i
   );

  tile_io_pkg::dev_sel_t [tile_io_pkg::num_src_p-1:0] dst;
  logic [tile_io_pkg::num_dev_p-1:0][tile_io_pkg::num_src_p-1:0] dev_req;
  // preferred requester per device
  tile_io_pkg::src_id_t [tile_io_pkg::num_dev_p-1:0] rr_r;

  for (genvar i = 0; i < tile_io_pkg::num_src_p; i++)
    begin : dec
      wire in_local = (src_addr_i[i].local_addr.upper == '0);
      wire is_cfg   = in_local & (src_addr_i[i].local_addr.dev == tile_io_pkg::cfg_dev_id_p);
      wire is_clint = in_local & (src_addr_i[i].local_addr.dev == tile_io_pkg::clint_dev_id_p);

      // anything not mapped falls to the loopback
      assign dst[i] = is_cfg   ? tile_io_pkg::dev_cfg_p
                    : is_clint ? tile_io_pkg::dev_clint_p
                    : tile_io_pkg::dev_loopback_p;

      assign src_ready_o[i] = src_v_i[i]
                            & (dev_src_o[dst[i]] == tile_io_pkg::src_id_t'(i))
                            & dev_ready_i[dst[i]];
    end

  for (genvar d = 0; d < tile_io_pkg::num_dev_p; d++)
    begin : xbar
      for (genvar i = 0; i < tile_io_pkg::num_src_p; i++)
        begin : req
          assign dev_req[d][i] = src_v_i[i] & (dst[i] == tile_io_pkg::dev_sel_t'(d));
        end

      // two requesters: take 1 when it is alone or when it holds the pointer
      assign dev_src_o[d] = dev_req[d][1] & (~dev_req[d][0] | rr_r[d]);

      assign dev_v_o[d]     = |dev_req[d];
      assign dev_addr_o[d]  = src_addr_i[dev_src_o[d]];
      assign dev_we_o[d]    = src_we_i[dev_src_o[d]];
      assign dev_wdata_o[d] = src_wdata_i[dev_src_o[d]];
    end

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        rr_r <= '0;
      else
        for (int d = 0; d < tile_io_pkg::num_dev_p; d++)
          begin
            // stick with a stalled winner, move past it once accepted
            if (dev_v_o[d] & dev_ready_i[d])
              rr_r[d] <= ~dev_src_o[d];
            else if (dev_v_o[d])
              rr_r[d] <= dev_src_o[d];
          end
    end

endmodule

// File: source/tile_rev_router.sv
`timescale 1ns/1ps

module tile_rev_router
  (input        [tile_io_pkg::num_dev_p-1:0]                     rsp_v_i
   , input      tile_io_pkg::data_t [tile_io_pkg::num_dev_p-1:0] rsp_data_i
   , input      tile_io_pkg::src_id_t [tile_io_pkg::num_dev_p-1:0] rsp_src_i
   , output logic [tile_io_pkg::num_dev_p-1:0]                   rsp_ready_o

   , output logic [tile_io_pkg::num_src_p-1:0]                   src_rsp_v_o
   , output tile_io_pkg::data_t [tile_io_pkg::num_src_p-1:0]     src_rsp_data_o
   , input        [tile_io_pkg::num_src_p-1:0]                   src_rsp_ready_i
   );

  always_comb
    begin
      src_rsp_v_o    = '0;
      src_rsp_data_o = '0;
      rsp_ready_o    = '0;
      for (int s = 0; s < tile_io_pkg::num_src_p; s++)
        for (int d = 0; d < tile_io_pkg::num_dev_p; d++)
          begin
            // lowest device index wins, later ones wait
            if (rsp_v_i[d] && !src_rsp_v_o[s]
                && (rsp_src_i[d] == tile_io_pkg::src_id_t'(s)))
              begin
                src_rsp_v_o[s]    = 1'b1;
                src_rsp_data_o[s] = rsp_data_i[d];
                rsp_ready_o[d]    = src_rsp_ready_i[s];
              end
          end
    end

endmodule

// File: source/tile_cfg_slice.sv
`timescale 1ns/1ps

module tile_cfg_slice
  (input                                clk_i
   , input                              reset_i

   , input                              req_v_i
   , input tile_io_pkg::tile_addr_u     req_addr_i
   , input                              req_we_i
   , input tile_io_pkg::data_t          req_wdata_i
   , input tile_io_pkg::src_id_t        req_src_i
   , output logic                       req_ready_o

   , output logic                       rsp_v_o
   , output tile_io_pkg::data_t         rsp_data_o
   , output tile_io_pkg::src_id_t       rsp_src_o
   , input                              rsp_ready_i

   , output logic                       freeze_o
   , output tile_io_pkg::data_t         boot_npc_o
   );

  logic                 freeze_r;
  tile_io_pkg::data_t   boot_npc_r;
  logic                 rsp_v_r;
  tile_io_pkg::data_t   rsp_data_r;
  tile_io_pkg::src_id_t rsp_src_r;
  tile_io_pkg::data_t   rd_data;
  logic [19:0]          offset;

  assign offset      = req_addr_i.local_addr.offset;
  // one response slot, take a new request only when it is empty
  assign req_ready_o = ~rsp_v_r;
  wire   accept      = req_v_i & req_ready_o;

  always_comb
    begin
      case (offset)
        tile_io_pkg::cfg_freeze_offset_p:   rd_data = {63'b0, freeze_r};
        tile_io_pkg::cfg_boot_npc_offset_p: rd_data = boot_npc_r;
        tile_io_pkg::cfg_core_id_offset_p:  rd_data = tile_io_pkg::core_id_p;
        default:                            rd_data = '0;
      endcase
    end

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        begin
          rsp_v_r    <= 1'b0;
          freeze_r   <= 1'b1;
          boot_npc_r <= tile_io_pkg::boot_npc_reset_p;
        end
      else
        begin
          if (accept)
            rsp_v_r <= 1'b1;
          else if (rsp_ready_i)
            rsp_v_r <= 1'b0;

          if (accept & req_we_i & (offset == tile_io_pkg::cfg_freeze_offset_p))
            freeze_r <= req_wdata_i[0];
          if (accept & req_we_i & (offset == tile_io_pkg::cfg_boot_npc_offset_p))
            boot_npc_r <= req_wdata_i;
        end
    end

  // writes answer with zero data
  always_ff @(posedge clk_i)
    begin
      if (accept)
        begin
          rsp_data_r <= req_we_i ? '0 : rd_data;
          rsp_src_r  <= req_src_i;
        end
    end

  assign rsp_v_o    = rsp_v_r;
  assign rsp_data_o = rsp_data_r;
  assign rsp_src_o  = rsp_src_r;
  assign freeze_o   = freeze_r;
  assign boot_npc_o = boot_npc_r;

endmodule

// File: source/tile_clint_slice.sv
`timescale 1ns/1ps

module tile_clint_slice
  (input                                clk_i
   , input                              rt_clk_i
   , input                              reset_i

   , input                              req_v_i
   , input tile_io_pkg::tile_addr_u     req_addr_i
   , input                              req_we_i
   , input tile_io_pkg::data_t          req_wdata_i
   , input tile_io_pkg::src_id_t        req_src_i
   , output logic                       req_ready_o

   , output logic                       rsp_v_o
   , output tile_io_pkg::data_t         rsp_data_o
   , output tile_io_pkg::src_id_t       rsp_src_o
   , input                              rsp_ready_i

   , output logic                       timer_irq_o
   , output logic                       software_irq_o
   );

  // [1:0] synchronize rt_clk_i, [2] holds the previous sample
  logic [2:0]           rt_sr_r;
  logic                 rt_tick;
  tile_io_pkg::data_t   mtime_r;
  tile_io_pkg::data_t   mtimecmp_r;
  logic                 mipi_r;
  logic                 rsp_v_r;
  tile_io_pkg::data_t   rsp_data_r;
  tile_io_pkg::src_id_t rsp_src_r;
  tile_io_pkg::data_t   rd_data;
  logic [19:0]          offset;

  assign rt_tick     = rt_sr_r[1] & ~rt_sr_r[2];
  assign offset      = req_addr_i.local_addr.offset;
  assign req_ready_o = ~rsp_v_r;
  wire   accept      = req_v_i & req_ready_o;
  wire   wr          = accept & req_we_i;

  always_comb
    begin
      case (offset)
        tile_io_pkg::clint_mipi_offset_p:     rd_data = {63'b0, mipi_r};
        tile_io_pkg::clint_mtimecmp_offset_p: rd_data = mtimecmp_r;
        tile_io_pkg::clint_mtime_offset_p:    rd_data = mtime_r;
        default:                              rd_data = '0;
      endcase
    end

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        begin
          rt_sr_r    <= '0;
          mtime_r    <= '0;
          mtimecmp_r <= tile_io_pkg::mtimecmp_reset_p;
          mipi_r     <= 1'b0;
          rsp_v_r    <= 1'b0;
        end
      else
        begin
          rt_sr_r <= {rt_sr_r[1:0], rt_clk_i};

          // a software write to mtime wins over the tick
          if (wr & (offset == tile_io_pkg::clint_mtime_offset_p))
            mtime_r <= req_wdata_i;
          else if (rt_tick)
            mtime_r <= mtime_r + 64'd1;

          if (wr & (offset == tile_io_pkg::clint_mtimecmp_offset_p))
            mtimecmp_r <= req_wdata_i;
          if (wr & (offset == tile_io_pkg::clint_mipi_offset_p))
            mipi_r <= req_wdata_i[0];

          if (accept)
            rsp_v_r <= 1'b1;
          else if (rsp_ready_i)
            rsp_v_r <= 1'b0;
        end
    end

  always_ff @(posedge clk_i)
    begin
      if (accept)
        begin
          rsp_data_r <= req_we_i ? '0 : rd_data;
          rsp_src_r  <= req_src_i;
        end
    end

  assign rsp_v_o        = rsp_v_r;
  assign rsp_data_o     = rsp_data_r;
  assign rsp_src_o      = rsp_src_r;
  assign timer_irq_o    = (mtime_r >= mtimecmp_r);
  assign software_irq_o = mipi_r;

endmodule

// File: source/tile_loopback.sv
`timescale 1ns/1ps

module tile_loopback
  (input                                clk_i
   , input                              reset_i

   , input                              req_v_i
   , input tile_io_pkg::src_id_t        req_src_i
   , output logic                       req_ready_o

   , output logic                       rsp_v_o
   , output tile_io_pkg::data_t         rsp_data_o
   , output tile_io_pkg::src_id_t       rsp_src_o
   , input                              rsp_ready_i
   );

  logic                 rsp_v_r;
  tile_io_pkg::src_id_t rsp_src_r;

  assign req_ready_o = ~rsp_v_r;
  wire   accept      = req_v_i & req_ready_o;

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        rsp_v_r <= 1'b0;
      else if (accept)
        rsp_v_r <= 1'b1;
      else if (rsp_ready_i)
        rsp_v_r <= 1'b0;
    end

  // only the return tag is kept
  always_ff @(posedge clk_i)
    begin
      if (accept)
        rsp_src_r <= req_src_i;
    end

  assign rsp_v_o    = rsp_v_r;
  assign rsp_data_o = '0;
  assign rsp_src_o  = rsp_src_r;

endmodule

// File: source/tile_io_complex.sv
`timescale 1ns/1ps

module tile_io_complex
  (input                                                           clk_i
   , input                                                         rt_clk_i
   , input                                                         reset_i

   , input        [tile_io_pkg::num_src_p-1:0]                     src_v_i
   , input        tile_io_pkg::tile_addr_u [tile_io_pkg::num_src_p-1:0] src_addr_i
   , input        [tile_io_pkg::num_src_p-1:0]                     src_we_i
   , input        tile_io_pkg::data_t [tile_io_pkg::num_src_p-1:0] src_wdata_i
   , output logic [tile_io_pkg::num_src_p-1:0]                     src_ready_o

   , output logic [tile_io_pkg::num_src_p-1:0]                     src_rsp_v_o
   , output tile_io_pkg::data_t [tile_io_pkg::num_src_p-1:0]       src_rsp_data_o
   , input        [tile_io_pkg::num_src_p-1:0]                     src_rsp_ready_i

   , output logic                                                  freeze_o
   , output tile_io_pkg::data_t                                    boot_npc_o
   , output logic                                                  timer_irq_o
   , output logic                                                  software_irq_o
   );

  // {loopback, clint, cfg}
  logic [tile_io_pkg::num_dev_p-1:0]                   dev_v, dev_we, dev_ready;
  tile_io_pkg::tile_addr_u [tile_io_pkg::num_dev_p-1:0] dev_addr;
  tile_io_pkg::data_t [tile_io_pkg::num_dev_p-1:0]     dev_wdata;
  tile_io_pkg::src_id_t [tile_io_pkg::num_dev_p-1:0]   dev_src;
  logic [tile_io_pkg::num_dev_p-1:0]                   rsp_v, rsp_ready;
  tile_io_pkg::data_t [tile_io_pkg::num_dev_p-1:0]     rsp_data;
  tile_io_pkg::src_id_t [tile_io_pkg::num_dev_p-1:0]   rsp_src;

  tile_fwd_router
   fwd
    (.clk_i(clk_i), .reset_i(reset_i)
     ,.src_v_i(src_v_i), .src_addr_i(src_addr_i), .src_we_i(src_we_i)
     ,.src_wdata_i(src_wdata_i), .src_ready_o(src_ready_o)
     ,.dev_v_o(dev_v), .dev_addr_o(dev_addr), .dev_we_o(dev_we)
     ,.dev_wdata_o(dev_wdata), .dev_src_o(dev_src), .dev_ready_i(dev_ready)
     );

  tile_cfg_slice
   cfgs
    (.clk_i(clk_i), .reset_i(reset_i)
     ,.req_v_i(dev_v[tile_io_pkg::dev_cfg_p]), .req_addr_i(dev_addr[tile_io_pkg::dev_cfg_p])
     ,.req_we_i(dev_we[tile_io_pkg::dev_cfg_p]), .req_wdata_i(dev_wdata[tile_io_pkg::dev_cfg_p])
     ,.req_src_i(dev_src[tile_io_pkg::dev_cfg_p]), .req_ready_o(dev_ready[tile_io_pkg::dev_cfg_p])
     ,.rsp_v_o(rsp_v[tile_io_pkg::dev_cfg_p]), .rsp_data_o(rsp_data[tile_io_pkg::dev_cfg_p])
     ,.rsp_src_o(rsp_src[tile_io_pkg::dev_cfg_p]), .rsp_ready_i(rsp_ready[tile_io_pkg::dev_cfg_p])
     ,.freeze_o(freeze_o), .boot_npc_o(boot_npc_o)
     );

  tile_clint_slice
   clint
    (.clk_i(clk_i), .rt_clk_i(rt_clk_i), .reset_i(reset_i)
     ,.req_v_i(dev_v[tile_io_pkg::dev_clint_p]), .req_addr_i(dev_addr[tile_io_pkg::dev_clint_p])
     ,.req_we_i(dev_we[tile_io_pkg::dev_clint_p])
     ,.req_wdata_i(dev_wdata[tile_io_pkg::dev_clint_p])
     ,.req_src_i(dev_src[tile_io_pkg::dev_clint_p])
     ,.req_ready_o(dev_ready[tile_io_pkg::dev_clint_p])
     ,.rsp_v_o(rsp_v[tile_io_pkg::dev_clint_p]), .rsp_data_o(rsp_data[tile_io_pkg::dev_clint_p])
     ,.rsp_src_o(rsp_src[tile_io_pkg::dev_clint_p])
     ,.rsp_ready_i(rsp_ready[tile_io_pkg::dev_clint_p])
     ,.timer_irq_o(timer_irq_o), .software_irq_o(software_irq_o)
     );

  tile_loopback
   loopback
    (.clk_i(clk_i), .reset_i(reset_i)
     ,.req_v_i(dev_v[tile_io_pkg::dev_loopback_p])
     ,.req_src_i(dev_src[tile_io_pkg::dev_loopback_p])
     ,.req_ready_o(dev_ready[tile_io_pkg::dev_loopback_p])
     ,.rsp_v_o(rsp_v[tile_io_pkg::dev_loopback_p])
     ,.rsp_data_o(rsp_data[tile_io_pkg::dev_loopback_p])
     ,.rsp_src_o(rsp_src[tile_io_pkg::dev_loopback_p])
     ,.rsp_ready_i(rsp_ready[tile_io_pkg::dev_loopback_p])
     );

  tile_rev_router
   rev
    (.rsp_v_i(rsp_v), .rsp_data_i(rsp_data), .rsp_src_i(rsp_src), .rsp_ready_o(rsp_ready)
     ,.src_rsp_v_o(src_rsp_v_o), .src_rsp_data_o(src_rsp_data_o)
     ,.src_rsp_ready_i(src_rsp_ready_i)
     );

endmodule

// File: dv/tile_io_complex_chk.sv
`timescale 1ns/1ps

module tile_io_complex_chk
  (input                                                          clk_i
   , input                                                        reset_i
   , input [tile_io_pkg::num_src_p-1:0]                           src_v_i
   , input [tile_io_pkg::num_src_p-1:0]                           src_ready_i
   , input tile_io_pkg::dev_sel_t [tile_io_pkg::num_src_p-1:0]    dst_i
   , input [tile_io_pkg::num_dev_p-1:0]                           dev_v_i
   , input tile_io_pkg::tile_addr_u [tile_io_pkg::num_dev_p-1:0]  dev_addr_i
   , input [tile_io_pkg::num_dev_p-1:0]                           dev_we_i
   , input tile_io_pkg::data_t [tile_io_pkg::num_dev_p-1:0]       dev_wdata_i
   , input tile_io_pkg::src_id_t [tile_io_pkg::num_dev_p-1:0]     dev_src_i
   , input [tile_io_pkg::num_dev_p-1:0]                           dev_ready_i
   );

  ready_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    (src_ready_i & ~src_v_i) == '0)
    else $error("requester ready without a valid request");

  for (genvar d = 0; d < tile_io_pkg::num_dev_p; d++)
    begin : per_dev
      // a device handshake belongs to exactly one granted requester
      one_grant: assert property (@(posedge clk_i) disable iff (reset_i)
        (dev_v_i[d] && dev_ready_i[d]) |->
          $onehot({src_ready_i[1] && (dst_i[1] == tile_io_pkg::dev_sel_t'(d)),
                   src_ready_i[0] && (dst_i[0] == tile_io_pkg::dev_sel_t'(d))}))
        else $error("device %0d handshake without exactly one grant", d);

      held_until_ready: assert property (@(posedge clk_i) disable iff (reset_i)
        (dev_v_i[d] && !dev_ready_i[d]) |=>
          (dev_v_i[d] && $stable(dev_addr_i[d]) && $stable(dev_we_i[d])
           && $stable(dev_wdata_i[d]) && $stable(dev_src_i[d])))
        else $error("device %0d request changed while stalled", d);
    end

endmodule

bind tile_fwd_router tile_io_complex_chk chk
  (.clk_i(clk_i), .reset_i(reset_i), .src_v_i(src_v_i), .src_ready_i(src_ready_o)
   ,.dst_i(dst), .dev_v_i(dev_v_o), .dev_addr_i(dev_addr_o), .dev_we_i(dev_we_o)
   ,.dev_wdata_i(dev_wdata_o), .dev_src_i(dev_src_o), .dev_ready_i(dev_ready_i)
   );

// File: dv/tile_io_complex_tb.sv
`timescale 1ns/1ps

module tile_io_complex_tb;

  localparam int wait_limit = 50;
  localparam int irq_limit  = 1000;

  typedef enum int {side_none, side_freeze, side_boot, side_sw, side_timer} side_e;

  typedef struct packed
  {
    tile_io_pkg::src_id_t    src;
    tile_io_pkg::tile_addr_u addr;
    logic                    we;
    tile_io_pkg::data_t      wdata;
    tile_io_pkg::data_t      exp;
    side_e                   side;
    tile_io_pkg::data_t      side_exp;
  } entry_t;

  logic clk_i;
  logic rt_clk_i;
  logic reset_i;
  logic [tile_io_pkg::num_src_p-1:0]                    src_v_i;
  tile_io_pkg::tile_addr_u [tile_io_pkg::num_src_p-1:0] src_addr_i;
  logic [tile_io_pkg::num_src_p-1:0]                    src_we_i;
  tile_io_pkg::data_t [tile_io_pkg::num_src_p-1:0]      src_wdata_i;
  logic [tile_io_pkg::num_src_p-1:0]                    src_ready_o;
  logic [tile_io_pkg::num_src_p-1:0]                    src_rsp_v_o;
  tile_io_pkg::data_t [tile_io_pkg::num_src_p-1:0]      src_rsp_data_o;
  logic [tile_io_pkg::num_src_p-1:0]                    src_rsp_ready_i;
  logic                                                 freeze_o;
  tile_io_pkg::data_t                                   boot_npc_o;
  logic                                                 timer_irq_o;
  logic                                                 software_irq_o;

  integer seed = 84984;
  bit     run_done = 1'b0;
  bit     fail_shown = 1'b0;
  entry_t table_q[$];

  tile_io_complex dut (.*);

  initial
    begin
      clk_i = 1'b0;
      forever
        #2 clk_i = ~clk_i;
    end

  // slow real-time clock, one edge every 5 cycles
  initial
    begin
      rt_clk_i = 1'b0;
      forever
        begin
          repeat (5) @(negedge clk_i);
          rt_clk_i = ~rt_clk_i;
        end
    end

  task automatic stop_run();
    $display("Result: FAILED");
    fail_shown = 1'b1;
    $fatal(1);
  endtask

  task automatic check_data(input tile_io_pkg::data_t got, input tile_io_pkg::data_t exp,
                            input string what);
    if (got !== exp)
      begin
        $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        stop_run();
      end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
      begin
        $display("Fail at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
        stop_run();
      end
  endtask

  function automatic tile_io_pkg::tile_addr_u make_addr(input logic [3:0] dev,
                                                        input logic [19:0] off);
    tile_io_pkg::tile_addr_u a;
    a.raw              = '0;
    a.local_addr.dev    = dev;
    a.local_addr.offset = off;
    return a;
  endfunction

  function automatic tile_io_pkg::data_t rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi, lo};
  endfunction

  function automatic void add_entry(input tile_io_pkg::src_id_t s,
                                    input tile_io_pkg::tile_addr_u a, input logic we,
                                    input tile_io_pkg::data_t wd, input tile_io_pkg::data_t ex,
                                    input side_e k, input tile_io_pkg::data_t kx);
    entry_t e;
    e.src      = s;
    e.addr     = a;
    e.we       = we;
    e.wdata    = wd;
    e.exp      = ex;
    e.side     = k;
    e.side_exp = kx;
    table_q.push_back(e);
  endfunction

  task automatic build_table();
    tile_io_pkg::data_t      rand_a;
    tile_io_pkg::data_t      rand_b;
    tile_io_pkg::tile_addr_u frz;
    tile_io_pkg::tile_addr_u boot;
    tile_io_pkg::tile_addr_u mipi;
    tile_io_pkg::tile_addr_u cmp;
    tile_io_pkg::tile_addr_u far;
    rand_a = rand_word();
    rand_b = rand_word();
    frz    = make_addr(tile_io_pkg::cfg_dev_id_p, tile_io_pkg::cfg_freeze_offset_p);
    boot   = make_addr(tile_io_pkg::cfg_dev_id_p, tile_io_pkg::cfg_boot_npc_offset_p);
    mipi   = make_addr(tile_io_pkg::clint_dev_id_p, tile_io_pkg::clint_mipi_offset_p);
    cmp    = make_addr(tile_io_pkg::clint_dev_id_p, tile_io_pkg::clint_mtimecmp_offset_p);
    // looks like the boot PC but sits outside the local region
    far.raw = 40'h12_3420_0008;

    add_entry(1'b0, frz, 1'b0, '0, 64'd1, side_freeze, 64'd1);
    add_entry(1'b0, boot, 1'b0, '0, 64'h8000_0000, side_boot, 64'h8000_0000);
    add_entry(1'b1, make_addr(tile_io_pkg::cfg_dev_id_p, tile_io_pkg::cfg_core_id_offset_p),
              1'b0, '0, 64'd5, side_none, '0);
    add_entry(1'b0, boot, 1'b1, rand_a, '0, side_boot, rand_a);
    add_entry(1'b0, boot, 1'b0, '0, rand_a, side_none, '0);
    add_entry(1'b1, boot, 1'b1, rand_b, '0, side_boot, rand_b);
    add_entry(1'b1, boot, 1'b0, '0, rand_b, side_none, '0);
    add_entry(1'b1, frz, 1'b1, '0, '0, side_freeze, '0);
    add_entry(1'b0, frz, 1'b0, '0, '0, side_none, '0);
    add_entry(1'b0, make_addr(4'h5, 20'h00100), 1'b0, '0, '0, side_none, '0);
    add_entry(1'b1, far, 1'b0, '0, '0, side_none, '0);
    add_entry(1'b0, far, 1'b1, rand_word(), '0, side_boot, rand_b);
    add_entry(1'b1, make_addr(tile_io_pkg::cfg_dev_id_p, 20'h00010), 1'b1, rand_word(), '0,
              side_none, '0);
    add_entry(1'b1, make_addr(tile_io_pkg::cfg_dev_id_p, 20'h00010), 1'b0, '0, '0,
              side_none, '0);
    add_entry(1'b0, boot, 1'b0, '0, rand_b, side_none, '0);
    add_entry(1'b0, mipi, 1'b1, 64'd1, '0, side_sw, 64'd1);
    add_entry(1'b1, mipi, 1'b0, '0, 64'd1, side_none, '0);
    add_entry(1'b1, mipi, 1'b1, '0, '0, side_sw, '0);
    add_entry(1'b0, cmp, 1'b1, 64'd40, '0, side_timer, 64'd1);
    add_entry(1'b1, cmp, 1'b0, '0, 64'd40, side_none, '0);
    add_entry(1'b1, cmp, 1'b1, '1, '0, side_timer, '0);
    add_entry(1'b0, cmp, 1'b0, '0, '1, side_none, '0);
  endtask

  task automatic wait_rsp(input tile_io_pkg::src_id_t s, output tile_io_pkg::data_t rd);
    int tries;
    tries = 0;
    while (!src_rsp_v_o[s])
      begin
        @(negedge clk_i);
        tries++;
        if (tries > wait_limit)
          begin
            $display("timeout: no response for requester %0d", s);
            stop_run();
          end
      end
    rd = src_rsp_data_o[s];
    @(posedge clk_i);
  endtask

  task automatic run_access(input tile_io_pkg::src_id_t s, input tile_io_pkg::tile_addr_u a,
                            input logic we, input tile_io_pkg::data_t wd,
                            output tile_io_pkg::data_t rd);
    int tries;
    @(negedge clk_i);
    src_v_i[s]     = 1'b1;
    src_addr_i[s]  = a;
    src_we_i[s]    = we;
    src_wdata_i[s] = wd;
    tries = 0;
    #1;
    while (!src_ready_o[s])
      begin
        @(negedge clk_i);
        #1;
        tries++;
        if (tries > wait_limit)
          begin
            $display("timeout: request from requester %0d never accepted", s);
            stop_run();
          end
      end
    @(negedge clk_i);
    src_v_i[s] = 1'b0;
    wait_rsp(s, rd);
  endtask

  task automatic wait_timer_irq(input logic level);
    int tries;
    tries = 0;
    while (timer_irq_o !== level)
      begin
        @(negedge clk_i);
        tries++;
        if (tries > irq_limit)
          begin
            $display("timeout: timer interrupt never reached %0b", level);
            stop_run();
          end
      end
  endtask

  // cfg and clint answer both requesters while responses are held off
  task automatic run_concurrent();
    logic [tile_io_pkg::num_src_p-1:0] pend;
    logic [tile_io_pkg::num_src_p-1:0] acc;
    int tries;
    @(negedge clk_i);
    src_rsp_ready_i = 2'b00;
    src_addr_i[0]   = make_addr(tile_io_pkg::cfg_dev_id_p, tile_io_pkg::cfg_core_id_offset_p);
    src_addr_i[1]   = make_addr(tile_io_pkg::clint_dev_id_p,
                                tile_io_pkg::clint_mtimecmp_offset_p);
    src_we_i        = 2'b00;
    src_wdata_i     = '0;
    src_v_i         = 2'b11;
    pend  = 2'b11;
    tries = 0;
    while (pend != 2'b00)
      begin
        #1;
        acc = pend & src_ready_o;
        @(negedge clk_i);
        pend    = pend & ~acc;
        src_v_i = src_v_i & ~acc;
        tries++;
        if (tries > wait_limit)
          begin
            $display("timeout: concurrent requests never both accepted");
            stop_run();
          end
      end
    repeat (6) @(negedge clk_i);
    tries = 0;
    while (src_rsp_v_o != 2'b11)
      begin
        @(negedge clk_i);
        tries++;
        if (tries > wait_limit)
          begin
            $display("timeout: concurrent responses not both pending");
            stop_run();
          end
      end
    check_data(src_rsp_data_o[0], 64'd5, "requester 0 core id under back-pressure");
    check_data(src_rsp_data_o[1], '1, "requester 1 mtimecmp under back-pressure");
    src_rsp_ready_i = 2'b11;
    @(negedge clk_i);
    check_bit(src_rsp_v_o[0], 1'b0, "requester 0 response drained");
    check_bit(src_rsp_v_o[1], 1'b0, "requester 1 response drained");
  endtask

  initial
    begin
      entry_t             e;
      tile_io_pkg::data_t rd;
      tile_io_pkg::data_t t0;
      tile_io_pkg::data_t t1;
      reset_i         = 1'b1;
      src_v_i         = '0;
      src_addr_i      = '0;
      src_we_i        = '0;
      src_wdata_i     = '0;
      src_rsp_ready_i = 2'b11;
      build_table();
      repeat (16) @(posedge clk_i);
      @(negedge clk_i);
      reset_i = 1'b0;

      @(negedge clk_i);
      check_bit(freeze_o, 1'b1, "freeze after reset");
      check_data(boot_npc_o, 64'h8000_0000, "boot pc after reset");
      check_bit(timer_irq_o, 1'b0, "timer irq after reset");
      check_bit(software_irq_o, 1'b0, "software irq after reset");

      foreach (table_q[n])
        begin
          e = table_q[n];
          run_access(e.src, e.addr, e.we, e.wdata, rd);
          check_data(rd, e.exp, $sformatf("entry %0d response data", n));
          @(negedge clk_i);
          case (e.side)
            side_freeze: check_bit(freeze_o, e.side_exp[0], $sformatf("entry %0d freeze", n));
            side_boot:   check_data(boot_npc_o, e.side_exp, $sformatf("entry %0d boot pc", n));
            side_sw:     check_bit(software_irq_o, e.side_exp[0],
                                   $sformatf("entry %0d software irq", n));
            side_timer:  wait_timer_irq(e.side_exp[0]);
            default: ;
          endcase
        end

      // mtime must never run backwards
      run_access(1'b0, make_addr(tile_io_pkg::clint_dev_id_p,
                                 tile_io_pkg::clint_mtime_offset_p), 1'b0, '0, t0);
      repeat (25) @(negedge clk_i);
      run_access(1'b1, make_addr(tile_io_pkg::clint_dev_id_p,
                                 tile_io_pkg::clint_mtime_offset_p), 1'b0, '0, t1);
      check_bit(t1 >= t0, 1'b1, "mtime non-decreasing");

      run_concurrent();

      run_done = 1'b1;
      $display("Result: PASSED");
      $finish;
    end

  final
    begin
      if (!run_done && !fail_shown)
        $display("Result: FAILED");
    end

endmodule

// File: sources.f
source/tile_io_pkg.sv
source/tile_fwd_router.sv
source/tile_rev_router.sv
source/tile_cfg_slice.sv
source/tile_clint_slice.sv
source/tile_loopback.sv
source/tile_io_complex.sv
dv/tile_io_complex_chk.sv
dv/tile_io_complex_tb.sv

// File: Makefile
TOP := tile_io_complex_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir
